// File: rtl/lc4_pkg.sv
// lc4 pipeline definitions
`default_nettype none

package lc4_pkg;

   localparam int WORD_W    = 16;  // data and address width
   localparam int REG_SEL_W = 3;   // eight registers

   localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;  // user code start
   localparam logic [WORD_W-1:0] NOP_INSN = 16'h0000;  // never-taken branch

   // opcodes, insn[15:12]
   localparam logic [3:0] OPC_ARITH   = 4'b0001;
   localparam logic [3:0] OPC_LOGIC   = 4'b0101;
   localparam logic [3:0] OPC_LDR     = 4'b0110;
   localparam logic [3:0] OPC_STR     = 4'b0111;
   localparam logic [3:0] OPC_CONST   = 4'b1001;
   localparam logic [3:0] OPC_HICONST = 4'b1101;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOT,
      ALU_PASS_IMM,  // const
      ALU_HICONST    // keep low byte of rs, imm8 on top
   } alu_op_e;

   // decoded control, travels with the insn down the pipe
   typedef struct packed {
      reg_sel_t rs_sel;
      reg_sel_t rt_sel;
      reg_sel_t rd_sel;
      logic     rs_re;
      logic     rt_re;
      logic     rd_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     use_imm;   // b operand is imm, not rt
      alu_op_e  alu_op;
      word_t    imm;       // extended immediate
   } ctrl_t;

   typedef struct packed {
      logic  valid;  // 0 for a bubble
      word_t pc;
      word_t insn;
   } fd_t;

   typedef struct packed {
      fd_t   fd;
      ctrl_t ctrl;
      word_t rs_data;
      word_t rt_data;
   } dx_t;

   typedef struct packed {
      fd_t   fd;
      ctrl_t ctrl;
      word_t alu_result;  // address for ldr/str
      word_t store_data;
   } xm_t;

   typedef struct packed {
      fd_t   fd;
      ctrl_t ctrl;
      word_t alu_result;
      word_t store_data;  // value actually written to dmem
      word_t load_data;
   } mw_t;

   // regfile write, also the w bypass source
   typedef struct packed {
      logic     we;
      reg_sel_t sel;
      word_t    data;
   } wb_t;

   // one record per retired insn
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t regfile_wsel;
      word_t    regfile_data;
      logic     nzp_we;
      logic [2:0] nzp_bits;
      logic     dmem_we;
      word_t    dmem_addr;
      word_t    dmem_data;
   } trace_t;

endpackage

`default_nettype wire

// File: rtl/lc4_pipe_reg.sv
// pipeline stage register
`timescale 1ns/100ps
`default_nettype none

module lc4_pipe_reg #(
   parameter type      payload_t = logic [15:0],
   parameter payload_t RESET_VAL = '0   // also the bubble value
) (
   input  wire           gwe,
   input  wire           i_arst_n,
   input  wire           i_hold,    // keep current contents
   input  wire           i_bubble,  // load RESET_VAL instead of i_d
   input  wire payload_t i_d,
   output payload_t      o_q
);

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_q <= RESET_VAL;
      end else if (i_bubble) begin
         o_q <= RESET_VAL;  // squash, valid and ctrl go to zero
      end else if (!i_hold) begin
         o_q <= i_d;
      end
   end

endmodule

`default_nettype wire

// File: rtl/lc4_regfile.sv
// eight entry register file
`timescale 1ns/100ps
`default_nettype none

module lc4_regfile (
   input  wire                gwe,
   input  wire                i_arst_n,
   input  wire lc4_pkg::reg_sel_t i_rs_sel,
   input  wire lc4_pkg::reg_sel_t i_rt_sel,
   output lc4_pkg::word_t     o_rs_data,
   output lc4_pkg::word_t     o_rt_data,
   input  wire lc4_pkg::wb_t  i_wb        // write port from w stage
);

   import lc4_pkg::*;

   word_t regs [2**REG_SEL_W];

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 2**REG_SEL_W; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.we) begin
         regs[i_wb.sel] <= i_wb.data;
      end
   end

   // write-through, so w and d can share a cycle
   assign o_rs_data = (i_wb.we && i_wb.sel == i_rs_sel) ? i_wb.data
                                                        : regs[i_rs_sel];
   assign o_rt_data = (i_wb.we && i_wb.sel == i_rt_sel) ? i_wb.data
                                                        : regs[i_rt_sel];

endmodule

`default_nettype wire

// File: rtl/lc4_decode.sv
// decode stage
`timescale 1ns/100ps
`default_nettype none

module lc4_decode (
   input  wire                 gwe,
   input  wire                 i_arst_n,
   input  wire lc4_pkg::fd_t   i_fd,
   input  wire lc4_pkg::ctrl_t i_x_ctrl,   // insn now in x, for load-use
   input  wire lc4_pkg::wb_t   i_wb,
   output lc4_pkg::dx_t        o_dx,
   output logic                o_stall,
   output lc4_pkg::word_t      o_next_pc,
   input  wire lc4_pkg::word_t i_pc        // f stage pc
);

   import lc4_pkg::*;

   word_t      insn;
   logic [3:0] opcode;
   word_t      imm5, imm6, imm9, imm8;
   logic       legal;    // insn is in the kept subset
   ctrl_t      ctrl;
   word_t      rs_data, rt_data;

   assign insn   = i_fd.valid ? i_fd.insn : NOP_INSN;  // bubbles decode as nop
   assign opcode = insn[15:12];

   assign imm5 = {{11{insn[4]}}, insn[4:0]};
   assign imm6 = {{10{insn[5]}}, insn[5:0]};
   assign imm9 = {{7{insn[8]}}, insn[8:0]};
   assign imm8 = {8'h00, insn[7:0]};  // hiconst byte, placed by the alu

   always_comb begin
      ctrl        = '0;
      legal       = 1'b0;
      ctrl.rd_sel = insn[11:9];
      ctrl.rs_sel = insn[8:6];
      ctrl.rt_sel = insn[2:0];
      unique case (opcode)
         OPC_ARITH: begin
            if (insn[5]) begin  // add imm5
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm5;
               legal        = 1'b1;
            end else if (!insn[3]) begin  // add / sub, mul and div dropped
               ctrl.alu_op = insn[4] ? ALU_SUB : ALU_ADD;
               ctrl.rt_re  = 1'b1;
               legal       = 1'b1;
            end
            ctrl.rs_re = 1'b1;
         end
         OPC_LOGIC: begin
            if (insn[5]) begin  // and imm5
               ctrl.alu_op  = ALU_AND;
               ctrl.use_imm = 1'b1;
               ctrl.imm     = imm5;
            end else begin
               case (insn[4:3])
                  2'b00:   ctrl.alu_op = ALU_AND;
                  2'b01:   ctrl.alu_op = ALU_NOT;
                  2'b10:   ctrl.alu_op = ALU_OR;
                  default: ctrl.alu_op = ALU_XOR;
               endcase
               ctrl.rt_re = (insn[4:3] != 2'b01);  // not has one source
            end
            ctrl.rs_re = 1'b1;
            legal      = 1'b1;
         end
         OPC_LDR: begin
            ctrl.rs_re   = 1'b1;
            ctrl.is_load = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.imm     = imm6;
            legal        = 1'b1;
         end
         OPC_STR: begin
            ctrl.rt_sel   = insn[11:9];  // data reg sits in the rd field
            ctrl.rs_re    = 1'b1;
            ctrl.rt_re    = 1'b1;
            ctrl.is_store = 1'b1;
            ctrl.use_imm  = 1'b1;
            ctrl.imm      = imm6;
            legal         = 1'b1;
         end
         OPC_CONST: begin
            ctrl.alu_op  = ALU_PASS_IMM;
            ctrl.use_imm = 1'b1;
            ctrl.imm     = imm9;
            legal        = 1'b1;
         end
         OPC_HICONST: begin
            ctrl.rs_sel  = insn[11:9];  // rd is also the source
            ctrl.rs_re   = 1'b1;
            ctrl.alu_op  = ALU_HICONST;
            ctrl.use_imm = 1'b1;
            ctrl.imm     = imm8;
            legal        = insn[8];     // insn[8] = 0 is not hiconst
         end
         default: ;
      endcase
      ctrl.rd_we  = legal && !ctrl.is_store;
      ctrl.nzp_we = ctrl.rd_we;   // every write sets nzp
      if (!legal) begin
         ctrl = '0;  // outside the subset, nop
      end
   end

   lc4_regfile regfile_inst (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs_sel  (ctrl.rs_sel),
      .i_rt_sel  (ctrl.rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_wb      (i_wb)
   );

   // load in x feeding an operand here, wait one cycle
   assign o_stall = i_x_ctrl.is_load &&
                    ((ctrl.rs_re && ctrl.rs_sel == i_x_ctrl.rd_sel) ||
                     (ctrl.rt_re && ctrl.rt_sel == i_x_ctrl.rd_sel));

   assign o_dx      = '{fd: i_fd, ctrl: ctrl, rs_data: rs_data, rt_data: rt_data};
   assign o_next_pc = i_pc + 16'd1;  // straight line, no branches

endmodule

`default_nettype wire

// File: rtl/lc4_execute.sv
// execute stage, bypass and alu
`timescale 1ns/100ps
`default_nettype none

module lc4_execute (
   input  wire lc4_pkg::dx_t i_dx,
   input  wire lc4_pkg::xm_t i_m,   // m stage, nearest bypass
   input  wire lc4_pkg::wb_t i_wb,  // w stage write
   output lc4_pkg::xm_t      o_xm
);

   import lc4_pkg::*;

   word_t rs_val, rt_val;  // operands after bypass
   word_t b_val;
   word_t alu_result;

   // youngest producer wins, m then w then regfile
   function automatic word_t bypass(input logic     re,
                                    input reg_sel_t sel,
                                    input word_t    rf_val,
                                    input xm_t      m,
                                    input wb_t      wb);
      word_t val;
      val = rf_val;
      if (re) begin
         if (m.ctrl.rd_we && m.ctrl.rd_sel == sel) begin
            val = m.alu_result;
         end else if (wb.we && wb.sel == sel) begin
            val = wb.data;
         end
      end
      return val;
   endfunction

   assign rs_val = bypass(i_dx.ctrl.rs_re, i_dx.ctrl.rs_sel, i_dx.rs_data, i_m, i_wb);
   assign rt_val = bypass(i_dx.ctrl.rt_re, i_dx.ctrl.rt_sel, i_dx.rt_data, i_m, i_wb);

   assign b_val = i_dx.ctrl.use_imm ? i_dx.ctrl.imm : rt_val;

   always_comb begin
      unique case (i_dx.ctrl.alu_op)
         ALU_ADD:      alu_result = rs_val + b_val;  // ldr/str address too
         ALU_SUB:      alu_result = rs_val - b_val;
         ALU_AND:      alu_result = rs_val & b_val;
         ALU_OR:       alu_result = rs_val | b_val;
         ALU_XOR:      alu_result = rs_val ^ b_val;
         ALU_NOT:      alu_result = ~rs_val;
         ALU_PASS_IMM: alu_result = i_dx.ctrl.imm;
         ALU_HICONST:  alu_result = {i_dx.ctrl.imm[7:0], rs_val[7:0]};
         default:      alu_result = '0;
      endcase
   end

   // rt goes on as store data, w may still patch it in m
   assign o_xm = '{fd: i_dx.fd, ctrl: i_dx.ctrl, alu_result: alu_result,
                   store_data: rt_val};

endmodule

`default_nettype wire

// File: rtl/lc4_result.sv
// memory and writeback stages
`timescale 1ns/100ps
`default_nettype none

module lc4_result (
   input  wire lc4_pkg::xm_t   i_m,
   input  wire lc4_pkg::mw_t   i_w,
   input  wire lc4_pkg::word_t i_dmem_rdata,
   output lc4_pkg::word_t      o_dmem_addr,
   output logic                o_dmem_we,
   output lc4_pkg::word_t      o_dmem_wdata,
   output lc4_pkg::mw_t        o_mw,
   output lc4_pkg::wb_t        o_wb,
   output lc4_pkg::trace_t     o_trace
);

   import lc4_pkg::*;

   word_t      m_store_data;
   word_t      w_data;      // value written back
   logic [2:0] w_nzp;
   logic       w_mem_op;

   // m stage
   assign w_data       = i_w.ctrl.is_load ? i_w.load_data : i_w.alu_result;
   assign m_store_data = (i_w.ctrl.rd_we && i_w.ctrl.rd_sel == i_m.ctrl.rt_sel)
                         ? w_data : i_m.store_data;  // w to m store bypass

   assign o_dmem_addr  = i_m.alu_result;
   assign o_dmem_we    = i_m.ctrl.is_store;
   assign o_dmem_wdata = m_store_data;

   assign o_mw = '{fd: i_m.fd, ctrl: i_m.ctrl, alu_result: i_m.alu_result,
                   store_data: m_store_data, load_data: i_dmem_rdata};

   // w stage
   assign w_nzp = w_data[15]      ? 3'b100 :   // n
                  (w_data == '0)  ? 3'b010 :   // z
                                    3'b001;    // p
   assign w_mem_op = i_w.ctrl.is_load || i_w.ctrl.is_store;

   assign o_wb = '{we: i_w.ctrl.rd_we, sel: i_w.ctrl.rd_sel, data: w_data};

   always_comb begin
      o_trace              = '0;
      o_trace.valid        = i_w.fd.valid;
      o_trace.pc           = i_w.fd.pc;
      o_trace.insn         = i_w.fd.insn;
      o_trace.regfile_we   = i_w.ctrl.rd_we;
      o_trace.regfile_wsel = i_w.ctrl.rd_sel;
      o_trace.regfile_data = w_data;
      o_trace.nzp_we       = i_w.ctrl.nzp_we;
      o_trace.nzp_bits     = w_nzp;
      o_trace.dmem_we      = i_w.ctrl.is_store;
      o_trace.dmem_addr    = w_mem_op ? i_w.alu_result : '0;
      if (i_w.ctrl.is_load) begin
         o_trace.dmem_data = i_w.load_data;
      end else if (i_w.ctrl.is_store) begin
         o_trace.dmem_data = i_w.store_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/lc4_core.sv
// lc4 five stage pipeline top
`timescale 1ns/100ps
`default_nettype none

module lc4_core (
   input  wire                 gwe,
   input  wire                 i_arst_n,
   output lc4_pkg::word_t      o_imem_addr,
   input  wire lc4_pkg::word_t i_imem_rdata,
   output lc4_pkg::word_t      o_dmem_addr,
   output logic                o_dmem_we,
   output lc4_pkg::word_t      o_dmem_wdata,
   input  wire lc4_pkg::word_t i_dmem_rdata,
   output lc4_pkg::trace_t     o_trace
);

   import lc4_pkg::*;

   word_t f_pc, next_pc;
   logic  stall;        // load-use, holds f and d
   fd_t   f_fd, d_fd;
   dx_t   d_dx, x_dx;
   xm_t   x_xm, m_xm;
   mw_t   m_mw, w_mw;
   wb_t   wb;

   // f stage
   lc4_pipe_reg #(.payload_t(word_t), .RESET_VAL(RESET_PC)) pc_reg_inst (
      .gwe (gwe), .i_arst_n (i_arst_n),
      .i_hold (stall), .i_bubble (1'b0),
      .i_d (next_pc), .o_q (f_pc)
   );

   assign o_imem_addr = f_pc;
   assign f_fd        = '{valid: 1'b1, pc: f_pc, insn: i_imem_rdata};

   lc4_pipe_reg #(.payload_t(fd_t)) fd_reg_inst (
      .gwe (gwe), .i_arst_n (i_arst_n),
      .i_hold (stall), .i_bubble (1'b0),
      .i_d (f_fd), .o_q (d_fd)
   );

   // d stage
   lc4_decode decode_inst (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_fd      (d_fd),
      .i_x_ctrl  (x_dx.ctrl),
      .i_wb      (wb),
      .o_dx      (d_dx),
      .o_stall   (stall),
      .o_next_pc (next_pc),
      .i_pc      (f_pc)
   );

   lc4_pipe_reg #(.payload_t(dx_t)) dx_reg_inst (
      .gwe (gwe), .i_arst_n (i_arst_n),
      .i_hold (1'b0), .i_bubble (stall),  // nop into x on stall
      .i_d (d_dx), .o_q (x_dx)
   );

   // x stage
   lc4_execute execute_inst (
      .i_dx (x_dx),
      .i_m  (m_xm),
      .i_wb (wb),
      .o_xm (x_xm)
   );

   lc4_pipe_reg #(.payload_t(xm_t)) xm_reg_inst (
      .gwe (gwe), .i_arst_n (i_arst_n),
      .i_hold (1'b0), .i_bubble (1'b0),
      .i_d (x_xm), .o_q (m_xm)
   );

   lc4_pipe_reg #(.payload_t(mw_t)) mw_reg_inst (
      .gwe (gwe), .i_arst_n (i_arst_n),
      .i_hold (1'b0), .i_bubble (1'b0),
      .i_d (m_mw), .o_q (w_mw)
   );

   // m and w stages
   lc4_result result_inst (
      .i_m          (m_xm),
      .i_w          (w_mw),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .o_mw         (m_mw),
      .o_wb         (wb),
      .o_trace      (o_trace)
   );

endmodule

`default_nettype wire

// File: verif/lc4_clk_gen.sv
// gwe clock and reset source
`timescale 1ns/100ps
`default_nettype none

module lc4_clk_gen #(
   parameter real PERIOD     = 8.0,  // ns
   parameter int  RST_CYCLES = 16
) (
   output logic o_gwe,
   output logic o_arst_n
);

   initial begin
      o_gwe    = 1'b0;
      o_arst_n = 1'b1;
      #1 o_arst_n = 1'b0;  // a real falling edge, ahead of the first gwe edge
   end

   always #(PERIOD / 2.0) o_gwe = ~o_gwe;

   initial begin
      repeat (RST_CYCLES) @(posedge o_gwe);
      @(negedge o_gwe);
      o_arst_n = 1'b1;  // release away from the rising edge
   end

endmodule

`default_nettype wire

// File: verif/tb_lc4_core.sv
// lc4 pipeline testbench
`timescale 1ns/100ps
`default_nettype none

module tb_lc4_core;

   import lc4_pkg::*;

   localparam int PROG_LEN = 64;
   localparam int TIMEOUT  = 16 + 3 * PROG_LEN + 40;  // reset + worst case stalls + drain

   logic   gwe, arst_n;
   word_t  imem_addr, imem_rdata;
   word_t  dmem_addr, dmem_wdata, dmem_rdata;
   logic   dmem_we;
   trace_t trace;

   int       seed;
   int       cycles;
   int       retired;
   word_t    prog [PROG_LEN];
   word_t    dut_mem [word_t];  // memory seen by the dut
   word_t    ref_mem [word_t];  // architectural copy for the model
   word_t    ref_regs [8];
   word_t    ref_pc;
   reg_sel_t last_rd;           // bias sources toward the latest write
   logic     dmem_we_seen;      // data bus of the insn now in w
   word_t    dmem_addr_seen, dmem_data_seen;

   lc4_clk_gen #(.PERIOD(8.0), .RST_CYCLES(16)) clk_gen_inst (
      .o_gwe    (gwe),
      .o_arst_n (arst_n)
   );

   lc4_core lc4_core_inst (
      .gwe          (gwe),
      .i_arst_n     (arst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_rdata (imem_rdata),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_we    (dmem_we),
      .o_dmem_wdata (dmem_wdata),
      .i_dmem_rdata (dmem_rdata),
      .o_trace      (trace)
   );

   function automatic word_t fetch_word(input word_t addr);
      word_t off;
      off = addr - RESET_PC;
      if (32'(off) < PROG_LEN) return prog[off[5:0]];
      return 16'h0000;  // past the program, nop
   endfunction

   function automatic word_t default_pattern(input word_t addr);
      return addr ^ 16'h5a5a;  // unwritten location
   endfunction

   function automatic logic [2:0] nzp_of(input word_t v);
      if (v[15]) return 3'b100;
      if (v == 16'h0000) return 3'b010;
      return 3'b001;
   endfunction

   function automatic reg_sel_t pick_src();
      if ($random(seed) % 2 == 0) return last_rd;
      return 3'($unsigned($random(seed)) % 8);
   endfunction

   task automatic build_program();
      int       kind;
      reg_sel_t d, s, t;
      logic [5:0] off;
      prog[0] = {4'b1001, 3'd6, 9'h040};        // const r6, pointer low byte
      prog[1] = {4'b1101, 3'd6, 1'b1, 8'h40};  // hiconst r6 -> 4040
      prog[2] = {4'b1001, 3'd7, 9'h060};
      prog[3] = {4'b1101, 3'd7, 1'b1, 8'h41};  // r7 -> 4160
      last_rd = 3'd7;
      for (int i = 4; i < PROG_LEN; i++) begin
         kind = $unsigned($random(seed)) % 11;
         d    = 3'($unsigned($random(seed)) % 6);  // r6 and r7 stay pointers
         s    = pick_src();
         t    = pick_src();
         off  = 6'($random(seed) % 8);              // small signed offset
         case (kind)
            0: prog[i] = {4'b0001, d, s, 3'b000, t};                 // add
            1: prog[i] = {4'b0001, d, s, 3'b010, t};                 // sub
            2: prog[i] = {4'b0001, d, s, 1'b1, 5'($random(seed))};  // add imm
            3: prog[i] = {4'b0101, d, s, 1'b0, 2'($random(seed)), t};
            4: prog[i] = {4'b0101, d, s, 1'b1, 5'($random(seed))};  // and imm
            5: prog[i] = {4'b1001, d, 9'($random(seed))};
            6: prog[i] = {4'b1101, d, 1'b1, 8'($random(seed))};
            7, 8: prog[i] = {4'b0110, d, 2'b11, 1'($random(seed)), off};  // ldr
            9: prog[i] = {4'b0111, t, 2'b11, 1'($random(seed)), off};     // str
            default: prog[i] = ($random(seed) % 2 == 0) ? 16'h0000
                               : {4'b1010, 12'($random(seed))};  // shifts, dropped
         endcase
         if (kind <= 8) last_rd = d;
      end
   endtask

   // architectural step of the next insn in program order
   function automatic trace_t ref_step();
      trace_t   tr;
      word_t    insn, r, addr;
      reg_sel_t d, s, t;
      logic     wr;
      tr   = '0;
      insn = fetch_word(ref_pc);
      d    = insn[11:9];
      s    = insn[8:6];
      t    = insn[2:0];
      wr   = 1'b0;
      r    = 16'h0000;
      tr.valid = 1'b1;
      tr.pc    = ref_pc;
      tr.insn  = insn;
      case (insn[15:12])
         4'b0001: begin
            if (insn[5]) begin
               r  = ref_regs[s] + {{11{insn[4]}}, insn[4:0]};
               wr = 1'b1;
            end else if (insn[5:3] == 3'b000) begin
               r  = ref_regs[s] + ref_regs[t];
               wr = 1'b1;
            end else if (insn[5:3] == 3'b010) begin
               r  = ref_regs[s] - ref_regs[t];
               wr = 1'b1;
            end
         end
         4'b0101: begin
            wr = 1'b1;
            if (insn[5]) r = ref_regs[s] & {{11{insn[4]}}, insn[4:0]};
            else begin
               case (insn[4:3])
                  2'b00:   r = ref_regs[s] & ref_regs[t];
                  2'b01:   r = ~ref_regs[s];
                  2'b10:   r = ref_regs[s] | ref_regs[t];
                  default: r = ref_regs[s] ^ ref_regs[t];
               endcase
            end
         end
         4'b0110: begin
            addr = ref_regs[s] + {{10{insn[5]}}, insn[5:0]};
            r    = ref_mem.exists(addr) ? ref_mem[addr] : default_pattern(addr);
            wr   = 1'b1;
            tr.dmem_addr = addr;
            tr.dmem_data = r;
         end
         4'b0111: begin
            addr = ref_regs[s] + {{10{insn[5]}}, insn[5:0]};
            ref_mem[addr] = ref_regs[d];  // data reg in the rd field
            tr.dmem_we   = 1'b1;
            tr.dmem_addr = addr;
            tr.dmem_data = ref_regs[d];
         end
         4'b1001: begin
            r  = {{7{insn[8]}}, insn[8:0]};
            wr = 1'b1;
         end
         4'b1101: begin
            if (insn[8]) begin
               r  = {insn[7:0], ref_regs[d][7:0]};
               wr = 1'b1;
            end
         end
         default: ;  // outside the subset, no effect
      endcase
      if (wr) begin
         tr.regfile_we   = 1'b1;
         tr.regfile_wsel = d;
         tr.regfile_data = r;
         tr.nzp_we       = 1'b1;
         tr.nzp_bits     = nzp_of(r);
         ref_regs[d]     = r;
      end
      ref_pc = ref_pc + 16'd1;
      return tr;
   endfunction

   task automatic expect_eq(input string name, input word_t exp, input word_t got);
      if (exp !== got) begin
         $display("[FAIL] %s exp %h got %h", name, exp, got);
         $display("SIMULATION FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // drive memory read data on the falling edge
   always @(negedge gwe) begin
      imem_rdata <= fetch_word(imem_addr);
      dmem_rdata <= dut_mem.exists(dmem_addr) ? dut_mem[dmem_addr]
                                              : default_pattern(dmem_addr);
   end

   // data memory write, and what the m stage put on the bus
   always @(posedge gwe) begin
      dmem_we_seen   <= arst_n && dmem_we;
      dmem_addr_seen <= dmem_addr;
      dmem_data_seen <= dmem_wdata;
      if (arst_n && dmem_we) dut_mem[dmem_addr] = dmem_wdata;
   end

   always @(posedge gwe) cycles <= cycles + 1;

   // comparison process
   always @(posedge gwe) begin
      trace_t exp;
      if (!arst_n) begin
         expect_eq("o_dmem_we", 16'h0000, 16'(dmem_we));
         expect_eq("o_trace.valid", 16'h0000, 16'(trace.valid));
         expect_eq("o_imem_addr", RESET_PC, imem_addr);  // first fetch address
      end else if (retired == 0 && !trace.valid) begin
         expect_eq("o_dmem_we", 16'h0000, 16'(dmem_we));
      end
      if (arst_n && trace.valid && retired < PROG_LEN) begin
         exp = ref_step();
         expect_eq("o_trace.pc", exp.pc, trace.pc);
         expect_eq("o_trace.insn", exp.insn, trace.insn);
         expect_eq("o_trace.regfile_we", 16'(exp.regfile_we), 16'(trace.regfile_we));
         if (exp.regfile_we) begin
            expect_eq("o_trace.regfile_wsel", 16'(exp.regfile_wsel),
                      16'(trace.regfile_wsel));
            expect_eq("o_trace.regfile_data", exp.regfile_data, trace.regfile_data);
         end
         expect_eq("o_trace.nzp_we", 16'(exp.nzp_we), 16'(trace.nzp_we));
         if (exp.nzp_we) begin
            expect_eq("o_trace.nzp_bits", 16'(exp.nzp_bits), 16'(trace.nzp_bits));
         end
         expect_eq("o_trace.dmem_we", 16'(exp.dmem_we), 16'(trace.dmem_we));
         expect_eq("o_trace.dmem_addr", exp.dmem_addr, trace.dmem_addr);
         expect_eq("o_trace.dmem_data", exp.dmem_data, trace.dmem_data);
         expect_eq("o_dmem_we", 16'(exp.dmem_we), 16'(dmem_we_seen));  // its m cycle
         if (exp.dmem_we) begin
            expect_eq("o_dmem_addr", exp.dmem_addr, dmem_addr_seen);
            expect_eq("o_dmem_wdata", exp.dmem_data, dmem_data_seen);
         end
         retired <= retired + 1;
      end
   end

   initial begin
      seed         = 51;
      cycles       = 0;
      retired      = 0;
      dmem_we_seen = 1'b0;
      imem_rdata   = 16'h0000;
      dmem_rdata   = 16'h0000;
      ref_pc       = RESET_PC;
      for (int i = 0; i < 8; i++) ref_regs[i] = 16'h0000;  // regfile resets to zero
      build_program();
      while (retired < PROG_LEN && cycles < TIMEOUT) @(posedge gwe);
      if (retired >= PROG_LEN) begin
         $display("SIMULATION PASSED");
         $finish;
      end else begin
         $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                  retired, PROG_LEN, cycles);
         $display("SIMULATION FAILED");
         $fatal(1, "timeout");
      end
   end

endmodule

`default_nettype wire

// File: flist.f
rtl/lc4_pkg.sv
rtl/lc4_pipe_reg.sv
rtl/lc4_regfile.sv
rtl/lc4_decode.sv
rtl/lc4_execute.sv
rtl/lc4_result.sv
rtl/lc4_core.sv
verif/lc4_clk_gen.sv
verif/tb_lc4_core.sv

// File: Makefile
# Verilator flow for the lc4 pipeline

VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_lc4_core
RTL_TOP   ?= lc4_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
